//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_aes_decipher_core
FILELIST  ?= aes_decipher_core.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the testbench printed the pass message
run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF -- '$(PASS_TEXT)'

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) \
		--top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- aes_decipher_core.f
hdl/aes_dec_pkg.sv
hdl/aes_inv_sbox.sv
hdl/aes_round_key_regs.sv
hdl/aes_dec_datapath.sv
hdl/aes_dec_ctrl.sv
hdl/aes_decipher_core.sv
testbench/aes_decipher_props.sv
testbench/tb_aes_decipher_core.sv

//--- hdl/aes_dec_ctrl.sv
// AES-128 decipher controller with req/ack handshake, round and word counters, sequencing FSM
`timescale 1ns/1ps

module aes_dec_ctrl
  import aes_dec_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        req,
  output logic        ack,
  output logic        load,
  output logic        step,
  output round_type_t round_type,
  output word_idx_t   word_idx,
  output round_idx_t  round_idx
);

  // Idle, working, holding the result, dropping ack
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DONE,
    ST_RELEASE
  } fsm_t;

  fsm_t       fsm_q;
  round_idx_t round_ctr_q;
  word_idx_t  word_ctr_q;
  logic       ack_q;
  logic       start;
  logic       last_word;

  // --------------------
  // Command decode
  // --------------------

  // New block accepted only from idle with ack low
  assign start = (fsm_q == ST_IDLE) && req && !ack_q;

  // First cycle in RUN loads ct with key 10
  assign load = (fsm_q == ST_RUN) && (round_ctr_q == AES128_ROUNDS);
  assign step = (fsm_q == ST_RUN) && (round_ctr_q != AES128_ROUNDS);

  // Column 3 ends a round
  assign last_word = step && (word_ctr_q == 2'd3);

  // Round type follows the count
  always_comb
  begin
    if (round_ctr_q == AES128_ROUNDS)
    begin
      round_type = RT_INIT;
    end
    else if (round_ctr_q == 4'd0)
    begin
      round_type = RT_FINAL;
    end
    else
    begin
      round_type = RT_MAIN;
    end
  end

  // --------------------
  // FSM and counters
  // --------------------

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      fsm_q       <= ST_IDLE;
      round_ctr_q <= '0;
      word_ctr_q  <= '0;
      ack_q       <= 1'b0;
    end
    else
    begin
      case (fsm_q)
        ST_IDLE:
        begin
          if (start)
          begin
            fsm_q       <= ST_RUN;
            round_ctr_q <= AES128_ROUNDS;
            word_ctr_q  <= '0;
          end
        end
        ST_RUN:
        begin
          if (load)
          begin
            round_ctr_q <= round_ctr_q - 4'd1;
          end
          else
          begin
            // Wraps back to column 0 after column 3
            word_ctr_q <= word_ctr_q + 2'd1;
            if (last_word && (round_ctr_q == 4'd0))
            begin
              // Final round done, result valid with ack
              fsm_q <= ST_DONE;
              ack_q <= 1'b1;
            end
            else if (last_word)
            begin
              round_ctr_q <= round_ctr_q - 4'd1;
            end
          end
        end
        ST_DONE:
        begin
          // Hold ack and pt until the host lets go of req
          if (!req)
          begin
            fsm_q <= ST_RELEASE;
          end
        end
        default:
        begin
          ack_q <= 1'b0;
          fsm_q <= ST_IDLE;
        end
      endcase
    end
  end

  assign ack       = ack_q;
  assign word_idx  = word_ctr_q;
  assign round_idx = round_ctr_q;

endmodule

//--- hdl/aes_dec_datapath.sv
// AES-128 decipher state register with InvShiftRows, word-serial InvSubBytes, AddRoundKey, InvMixColumns
`timescale 1ns/1ps

module aes_dec_datapath
  import aes_dec_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  block_t      ct,
  input  logic        load,
  input  logic        step,
  input  round_type_t round_type,
  input  word_idx_t   word_idx,
  input  block_t      round_key,
  output word_t       sbox_in,
  input  word_t       sbox_out,
  output block_t      state
);

  // --------------------
  // Round helpers
  // --------------------

  // Row r rotates right by r columns
  function automatic block_t inv_shift_rows(input block_t s);
    block_t r;
    for (int c = 0; c < 4; c++)
    begin
      for (int row = 0; row < 4; row++)
      begin
        r[127 - 8*(4*c + row) -: 8] = s[127 - 8*(4*((c - row + 4) % 4) + row) -: 8];
      end
    end
    return r;
  endfunction

  // Inverse MixColumns on one column
  function automatic word_t inv_mix_column(input word_t w);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    a0 = w[31:24];
    a1 = w[23:16];
    a2 = w[15:8];
    a3 = w[7:0];
    return {gf_mul14(a0) ^ gf_mul11(a1) ^ gf_mul13(a2) ^ gf_mul9(a3),
            gf_mul9(a0) ^ gf_mul14(a1) ^ gf_mul11(a2) ^ gf_mul13(a3),
            gf_mul13(a0) ^ gf_mul9(a1) ^ gf_mul14(a2) ^ gf_mul11(a3),
            gf_mul11(a0) ^ gf_mul13(a1) ^ gf_mul9(a2) ^ gf_mul14(a3)};
  endfunction

  block_t state_q;
  block_t shifted;
  block_t sub_src;
  block_t sub_state;
  block_t keyed;
  block_t mixed;

  // --------------------
  // Word-serial InvSubBytes
  // --------------------

  assign shifted = inv_shift_rows(state_q);

  // Word 0 shifts the whole state
  // Later words see a register that is already shifted
  assign sub_src = (word_idx == 2'd0) ? shifted : state_q;

  // Selected column goes through the S-box
  assign sbox_in = sub_src[127 - 32*word_idx -: 32];

  // Put the substituted column back in place
  always_comb
  begin
    sub_state = sub_src;
    sub_state[127 - 32*word_idx -: 32] = sbox_out;
  end

  // --------------------
  // AddRoundKey and InvMixColumns
  // --------------------

  assign keyed = sub_state ^ round_key;

  always_comb
  begin
    for (int c = 0; c < 4; c++)
    begin
      mixed[127 - 32*c -: 32] = inv_mix_column(keyed[127 - 32*c -: 32]);
    end
  end

  // --------------------
  // State register
  // --------------------

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_q <= '0;
    end
    else if (load)
    begin
      // Initial AddRoundKey with key 10
      state_q <= ct ^ round_key;
    end
    else if (step)
    begin
      if (word_idx == 2'd3)
      begin
        // Last column closes the round
        state_q <= (round_type == RT_MAIN) ? mixed : keyed;
      end
      else
      begin
        state_q <= sub_state;
      end
    end
  end

  // Holds the plaintext once the final round is done
  assign state = state_q;

endmodule

//--- hdl/aes_dec_pkg.sv
// AES-128 decipher shared types, round type enumeration, round count and GF(2^8) multiply functions
package aes_dec_pkg;

  // --------------------
  // Data types
  // --------------------

  // Full AES state or round key, byte 0 sits in bits 127:120
  typedef logic [127:0] block_t;

  // One state column of four bytes
  typedef logic [31:0] word_t;

  // Round key index 0 to 10
  typedef logic [3:0] round_idx_t;

  // Column index within the state
  typedef logic [1:0] word_idx_t;

  // Which flavour of round is being run
  typedef enum logic [1:0] {
    RT_INIT,
    RT_MAIN,
    RT_FINAL
  } round_type_t;

  // Host write port for the round key registers
  typedef struct packed {
    logic       valid;
    round_idx_t idx;
    block_t     key;
  } key_wr_t;

  // Rounds following the initial AddRoundKey
  localparam round_idx_t AES128_ROUNDS = 4'd10;

  // --------------------
  // GF(2^8) multiplies
  // --------------------

  // xtime with the AES reduction polynomial
  function automatic logic [7:0] gf_mul2(input logic [7:0] op);
    return {op[6:0], 1'b0} ^ (8'h1b & {8{op[7]}});
  endfunction

  // 9 = 8 + 1
  function automatic logic [7:0] gf_mul9(input logic [7:0] op);
    return gf_mul2(gf_mul2(gf_mul2(op))) ^ op;
  endfunction

  // 11 = 8 + 2 + 1
  function automatic logic [7:0] gf_mul11(input logic [7:0] op);
    return gf_mul2(gf_mul2(gf_mul2(op))) ^ gf_mul2(op) ^ op;
  endfunction

  // 13 = 8 + 4 + 1
  function automatic logic [7:0] gf_mul13(input logic [7:0] op);
    return gf_mul2(gf_mul2(gf_mul2(op))) ^ gf_mul2(gf_mul2(op)) ^ op;
  endfunction

  // 14 = 8 + 4 + 2
  function automatic logic [7:0] gf_mul14(input logic [7:0] op);
    return gf_mul2(gf_mul2(gf_mul2(op))) ^ gf_mul2(gf_mul2(op)) ^ gf_mul2(op);
  endfunction

endpackage

//--- hdl/aes_decipher_core.sv
// AES-128 decipher top level joining controller, datapath, round key registers and inverse S-box
`timescale 1ns/1ps

module aes_decipher_core
  import aes_dec_pkg::*;
(
  input  logic    clk,
  input  logic    reset_n,
  input  logic    req,
  input  block_t  ct,
  input  key_wr_t key_wr,
  output logic    ack,
  output block_t  pt
);

  // Controller to datapath
  logic        load;
  logic        step;
  round_type_t round_type;
  word_idx_t   word_idx;

  // Key select and S-box links
  round_idx_t  round_idx;
  block_t      round_key;
  word_t       sbox_in;
  word_t       sbox_out;

  // --------------------
  // Sequencing
  // --------------------

  aes_dec_ctrl ctrl_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .req        (req),
    .ack        (ack),
    .load       (load),
    .step       (step),
    .round_type (round_type),
    .word_idx   (word_idx),
    .round_idx  (round_idx)
  );

  // --------------------
  // Keys and datapath
  // --------------------

  aes_round_key_regs key_regs_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .key_wr    (key_wr),
    .round_idx (round_idx),
    .round_key (round_key)
  );

  // pt is the state register itself
  aes_dec_datapath datapath_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .ct         (ct),
    .load       (load),
    .step       (step),
    .round_type (round_type),
    .word_idx   (word_idx),
    .round_key  (round_key),
    .sbox_in    (sbox_in),
    .sbox_out   (sbox_out),
    .state      (pt)
  );

  aes_inv_sbox inv_sbox_i (
    .sbox_in  (sbox_in),
    .sbox_out (sbox_out)
  );

endmodule

//--- hdl/aes_inv_sbox.sv
// Inverse S-box applied to the four bytes of one 32-bit state column
`timescale 1ns/1ps

module aes_inv_sbox
  import aes_dec_pkg::*;
(
  input  word_t sbox_in,
  output word_t sbox_out
);

  // --------------------
  // Inverse substitution table
  // --------------------

  // Indexed by input byte value
  localparam logic [7:0] INV_SBOX [256] = '{
    8'h52, 8'h09, 8'h6a, 8'hd5, 8'h30, 8'h36, 8'ha5, 8'h38,
    8'hbf, 8'h40, 8'ha3, 8'h9e, 8'h81, 8'hf3, 8'hd7, 8'hfb,
    8'h7c, 8'he3, 8'h39, 8'h82, 8'h9b, 8'h2f, 8'hff, 8'h87,
    8'h34, 8'h8e, 8'h43, 8'h44, 8'hc4, 8'hde, 8'he9, 8'hcb,
    8'h54, 8'h7b, 8'h94, 8'h32, 8'ha6, 8'hc2, 8'h23, 8'h3d,
    8'hee, 8'h4c, 8'h95, 8'h0b, 8'h42, 8'hfa, 8'hc3, 8'h4e,
    8'h08, 8'h2e, 8'ha1, 8'h66, 8'h28, 8'hd9, 8'h24, 8'hb2,
    8'h76, 8'h5b, 8'ha2, 8'h49, 8'h6d, 8'h8b, 8'hd1, 8'h25,
    8'h72, 8'hf8, 8'hf6, 8'h64, 8'h86, 8'h68, 8'h98, 8'h16,
    8'hd4, 8'ha4, 8'h5c, 8'hcc, 8'h5d, 8'h65, 8'hb6, 8'h92,
    8'h6c, 8'h70, 8'h48, 8'h50, 8'hfd, 8'hed, 8'hb9, 8'hda,
    8'h5e, 8'h15, 8'h46, 8'h57, 8'ha7, 8'h8d, 8'h9d, 8'h84,
    8'h90, 8'hd8, 8'hab, 8'h00, 8'h8c, 8'hbc, 8'hd3, 8'h0a,
    8'hf7, 8'he4, 8'h58, 8'h05, 8'hb8, 8'hb3, 8'h45, 8'h06,
    8'hd0, 8'h2c, 8'h1e, 8'h8f, 8'hca, 8'h3f, 8'h0f, 8'h02,
    8'hc1, 8'haf, 8'hbd, 8'h03, 8'h01, 8'h13, 8'h8a, 8'h6b,
    8'h3a, 8'h91, 8'h11, 8'h41, 8'h4f, 8'h67, 8'hdc, 8'hea,
    8'h97, 8'hf2, 8'hcf, 8'hce, 8'hf0, 8'hb4, 8'he6, 8'h73,
    8'h96, 8'hac, 8'h74, 8'h22, 8'he7, 8'had, 8'h35, 8'h85,
    8'he2, 8'hf9, 8'h37, 8'he8, 8'h1c, 8'h75, 8'hdf, 8'h6e,
    8'h47, 8'hf1, 8'h1a, 8'h71, 8'h1d, 8'h29, 8'hc5, 8'h89,
    8'h6f, 8'hb7, 8'h62, 8'h0e, 8'haa, 8'h18, 8'hbe, 8'h1b,
    8'hfc, 8'h56, 8'h3e, 8'h4b, 8'hc6, 8'hd2, 8'h79, 8'h20,
    8'h9a, 8'hdb, 8'hc0, 8'hfe, 8'h78, 8'hcd, 8'h5a, 8'hf4,
    8'h1f, 8'hdd, 8'ha8, 8'h33, 8'h88, 8'h07, 8'hc7, 8'h31,
    8'hb1, 8'h12, 8'h10, 8'h59, 8'h27, 8'h80, 8'hec, 8'h5f,
    8'h60, 8'h51, 8'h7f, 8'ha9, 8'h19, 8'hb5, 8'h4a, 8'h0d,
    8'h2d, 8'he5, 8'h7a, 8'h9f, 8'h93, 8'hc9, 8'h9c, 8'hef,
    8'ha0, 8'he0, 8'h3b, 8'h4d, 8'hae, 8'h2a, 8'hf5, 8'hb0,
    8'hc8, 8'heb, 8'hbb, 8'h3c, 8'h83, 8'h53, 8'h99, 8'h61,
    8'h17, 8'h2b, 8'h04, 8'h7e, 8'hba, 8'h77, 8'hd6, 8'h26,
    8'he1, 8'h69, 8'h14, 8'h63, 8'h55, 8'h21, 8'h0c, 8'h7d
  };

  // --------------------
  // Byte lookups
  // --------------------

  // Same table for every byte lane
  always_comb
  begin
    for (int b = 0; b < 4; b++)
    begin
      sbox_out[8*b +: 8] = INV_SBOX[sbox_in[8*b +: 8]];
    end
  end

endmodule

//--- hdl/aes_round_key_regs.sv
// Eleven host-written round key registers with a combinational read port
`timescale 1ns/1ps

module aes_round_key_regs
  import aes_dec_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  key_wr_t    key_wr,
  input  round_idx_t round_idx,
  output block_t     round_key
);

  // Keys 0 to 10
  localparam int NUM_KEYS = AES128_ROUNDS + 1;

  block_t keys_q [NUM_KEYS];
  logic   wr_hit;

  // Writes to indices above 10 are dropped
  assign wr_hit = key_wr.valid && (key_wr.idx <= AES128_ROUNDS);

  // --------------------
  // Key storage
  // --------------------

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      for (int i = 0; i < NUM_KEYS; i++)
      begin
        keys_q[i] <= '0;
      end
    end
    else if (wr_hit)
    begin
      // One key per clock
      keys_q[key_wr.idx] <= key_wr.key;
    end
  end

  // --------------------
  // Read port
  // --------------------

  // Out of range index reads as zero
  assign round_key = (round_idx <= AES128_ROUNDS) ? keys_q[round_idx] : '0;

endmodule

//--- testbench/aes_dec_vectors.txt
// One 128-bit hex value per line
// Record: block count N, round keys 0 to 10, then N pairs of ciphertext, expected plaintext
// A count of zero ends the file
// FIPS-197 appendix C.1 key schedule
1
000102030405060708090a0b0c0d0e0f
d6aa74fdd2af72fadaa678f1d6ab76fe
b692cf0b643dbdf1be9bc5006830b3fe
b6ff744ed2c2c9bf6c590cbf0469bf41
47f7f7bc95353e03f96c32bcfd058dfd
3caaa3e8a99f9deb50f3af57adf622aa
5e390f7df7a69296a7553dc10aa31f6b
14f9701ae35fe28c440adf4d4ea9c026
47438735a41c65b9e016baf4aebf7ad2
549932d1f08557681093ed9cbe2c974e
13111d7fe3944a17f307a78b4d2b30c5
69c4e0d86a7b0430d8cdb78070b4c55a
00112233445566778899aabbccddeeff
// FIPS-197 appendix B key schedule, SP 800-38A ECB blocks after the first pair
5
2b7e151628aed2a6abf7158809cf4f3c
a0fafe1788542cb123a339392a6c7605
f2c295f27a96b9435935807a7359f67f
3d80477d4716fe3e1e237e446d7a883b
ef44a541a8525b7fb671253bdb0bad00
d4d1c6f87c839d87caf2b8bc11f915bc
6d88a37a110b3efddbf98641ca0093fd
4e54f70e5f5fc9f384a64fb24ea6dc4f
ead27321b58dbad2312bf5607f8d292f
ac7766f319fadc2128d12941575c006e
d014f9a8c9ee2589e13f0cc8b6630ca6
3925841d02dc09fbdc118597196a0b32
3243f6a8885a308d313198a2e0370734
3ad77bb40d7a3660a89ecaf32466ef97
6bc1bee22e409f96e93d7e117393172a
f5d3d58503b9699de785895a96fdbaaf
ae2d8a571e03ac9c9eb76fac45af8e51
43b1cd7f598ece23881b00e3ed030688
30c81c46a35ce411e5fbc1191a0a52ef
7b0c785e27e8ad3f8223207104725dd4
f69f2445df4f9b17ad2b417be66c3710
0

//--- testbench/aes_decipher_props.sv
// Handshake and key write assertions bound to the AES-128 decipher top level
`timescale 1ns/1ps

module aes_decipher_props
  import aes_dec_pkg::*;
(
  input logic    clk,
  input logic    reset_n,
  input logic    req,
  input logic    ack,
  input block_t  pt,
  input key_wr_t key_wr
);

  int unsigned prop_errors = 0;

  // ack only answers a request
  ack_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(ack) |-> $past(req))
    else
    begin
      prop_errors++;
      $error("ack rose with no request pending");
    end

  // Result frozen while acknowledged
  pt_stable: assert property (@(posedge clk) disable iff (!reset_n)
    ack && $past(ack) |-> $stable(pt))
    else
    begin
      prop_errors++;
      $error("pt changed while ack was high");
    end

  ack_after_req: assert property (@(posedge clk) disable iff (!reset_n)
    $fell(ack) |-> !$past(req))
    else
    begin
      prop_errors++;
      $error("ack fell while req was still high");
    end

  // req or ack high marks a block in flight
  no_key_write_busy: assert property (@(posedge clk) disable iff (!reset_n)
    key_wr.valid |-> !req && !ack)
    else
    begin
      prop_errors++;
      $error("round key written during a request");
    end

endmodule

bind aes_decipher_core aes_decipher_props props_i (
  .clk     (clk),
  .reset_n (reset_n),
  .req     (req),
  .ack     (ack),
  .pt      (pt),
  .key_wr  (key_wr)
);

//--- testbench/tb_aes_decipher_core.sv
// Testbench for the AES-128 decipher core: clock, reset, vector reader, handshake driver, checks
`timescale 1ns/1ps

module tb_aes_decipher_core
  import aes_dec_pkg::*;
();

  // Cycles from the sampling clock to ack high
  localparam int ACK_LATENCY = 41;
  localparam int MAX_GAP     = 5;
  localparam int MAX_HOLD    = 4;
  localparam int VEC_DEPTH   = 64;

  logic    clk;
  logic    reset_n;
  logic    req;
  block_t  ct;
  key_wr_t key_wr;
  logic    ack;
  block_t  pt;

  block_t  vec_mem [VEC_DEPTH];
  integer  seed;
  int      cycle_cnt;
  int      cycle_limit;

  aes_decipher_core aes_decipher_core_i (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (req),
    .ct      (ct),
    .key_wr  (key_wr),
    .ack     (ack),
    .pt      (pt)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // --------------------
  // Error handling
  // --------------------

  task automatic stop_on_error();
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_block(input block_t actual, input block_t expected, input string what);
    if (actual !== expected)
    begin
      $display("mismatch at %0t: %s, got %h expected %h", $time, what, actual, expected);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input logic actual, input logic expected, input string what);
    if (actual !== expected)
    begin
      $display("mismatch at %0t: %s, got %b expected %b", $time, what, actual, expected);
      stop_on_error();
    end
  endtask

  // Hang guard, limit is set once the vectors are counted
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit)
    begin
      $display("timeout after %0d cycles, a handshake never completed", cycle_cnt);
      stop_on_error();
    end
  end

  // --------------------
  // Host side
  // --------------------

  // Every task starts and ends 1 ns after a rising edge
  task automatic load_key_set(input int base);
    for (int i = 0; i <= 10; i++)
    begin
      key_wr.valid = 1'b1;
      key_wr.idx   = round_idx_t'(i);
      key_wr.key   = vec_mem[base + i];
      @(posedge clk);
      #1;
    end
    key_wr = '0;
  endtask

  task automatic idle_gap(input int cycles);
    repeat (cycles)
    begin
      @(posedge clk);
      #1;
      check_bit(ack, 1'b0, "ack while idle");
    end
  endtask

  task automatic decrypt_block(input block_t ct_val, input block_t pt_exp);
    int hold;
    ct  = ct_val;
    req = 1'b1;
    // Core is idle with ack low, so the next edge samples
    @(posedge clk);
    // ack must rise on exactly the 41st edge after sampling
    for (int c = 1; c <= ACK_LATENCY; c++)
    begin
      @(posedge clk);
      #1;
      check_bit(ack, c == ACK_LATENCY, "ack latency");
    end
    check_block(pt, pt_exp, "plaintext");
    // Back-pressure with req still high
    hold = $unsigned($random(seed)) % (MAX_HOLD + 1);
    repeat (hold)
    begin
      @(posedge clk);
      #1;
      check_bit(ack, 1'b1, "ack held while req high");
      check_block(pt, pt_exp, "pt held while ack high");
    end
    req = 1'b0;
    // Core sees req low, ack drops one edge later
    @(posedge clk);
    #1;
    check_bit(ack, 1'b1, "ack on the edge that sees req low");
    check_block(pt, pt_exp, "pt until ack falls");
    @(posedge clk);
    #1;
    check_bit(ack, 1'b0, "ack release");
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial
  begin
    int pos;
    int n_blocks;
    int n_vec;
    int n_sets;
    clk       = 1'b0;
    reset_n   = 1'b0;
    req       = 1'b0;
    ct        = '0;
    key_wr    = '0;
    seed      = 32'h54df;
    cycle_cnt = 0;
    $readmemh("testbench/aes_dec_vectors.txt", vec_mem);

    // Count records: block count, 11 keys, then ct and pt pairs
    pos    = 0;
    n_vec  = 0;
    n_sets = 0;
    while ((pos < VEC_DEPTH) && (vec_mem[pos] != '0))
    begin
      n_blocks = int'(vec_mem[pos][15:0]);
      n_vec   += n_blocks;
      n_sets++;
      pos     += 12 + 2 * n_blocks;
    end
    cycle_limit = n_vec * (ACK_LATENCY + MAX_GAP + MAX_HOLD + 4) + n_sets * 12 + 16;
    if (n_vec == 0)
    begin
      $display("vector file holds no blocks to decrypt");
      stop_on_error();
    end

    // Two cycles of reset
    repeat (2) @(posedge clk);
    #1;
    reset_n = 1'b1;
    idle_gap(4);

    pos = 0;
    while ((pos < VEC_DEPTH) && (vec_mem[pos] != '0))
    begin
      n_blocks = int'(vec_mem[pos][15:0]);
      load_key_set(pos + 1);
      for (int b = 0; b < n_blocks; b++)
      begin
        idle_gap($unsigned($random(seed)) % (MAX_GAP + 1));
        decrypt_block(vec_mem[pos + 12 + 2 * b], vec_mem[pos + 13 + 2 * b]);
      end
      pos += 12 + 2 * n_blocks;
    end

    // Bound assertions count their own failures
    if (aes_decipher_core_i.props_i.prop_errors == 0)
    begin
      $display("*** PASSED ***");
      $finish;
    end
    else
    begin
      $display("%0d handshake or key write assertions failed",
               aes_decipher_core_i.props_i.prop_errors);
      stop_on_error();
    end
  end

endmodule
